// ==== hw/fifoGeometryPkg.sv ====
//========================================
// FIFO word and pointer width defaults
// Storage depth derived from pointer width
//========================================
`default_nettype none

package fifoGeometryPkg;

    //========================================
    // Width defaults
    //========================================

    // Default FIFO word width in bits
    localparam int DefaultDataWidth = 8;

    // Default pointer width, 16 locations
    localparam int DefaultAddrWidth = 4;

    // Quadrant decode needs the two top pointer bits
    localparam int MinAddrWidth = 2;

    //========================================
    // Depth derivation
    //========================================

    // Locations addressed by a pointer of this width
    function automatic int fifoDepth(input int addrWidth);
        return 1 << addrWidth;
    endfunction

endpackage

`default_nettype wire

// ==== hw/fifoStatusPkg.sv ====
//========================================
// Direction state and pointer quadrant names
//========================================
`default_nettype none

package fifoStatusPkg;

    // Direction of travel between write and read pointers
    // Decides full versus empty once the pointers meet
    typedef enum logic {
        DirGoingEmpty = 1'b0,
        DirGoingFull  = 1'b1
    } dirState_t;

    //========================================
    // Pointer quadrants
    //========================================

    // Top two Gray bits of a pointer
    // Listed in the order a Gray count visits them
    typedef enum logic [1:0] {
        Q0 = 2'b00,
        Q1 = 2'b01,
        Q2 = 2'b11,
        Q3 = 2'b10
    } quadrant_t;

    // Q3 wraps back to Q0 when the pointer rolls over

endpackage

`default_nettype wire

// ==== hw/fifoGrayCounter.sv ====
//========================================
// Gray-code pointer counter with enable
// Asynchronous clear, one-bit-change check
//========================================
`timescale 1ns/1ps
`default_nettype none

module fifoGrayCounter
    import fifoGeometryPkg::*;
#(
    parameter int CountWidth = DefaultAddrWidth
) (
    input  wire                   Clk,
    input  wire                   Clear,
    input  wire                   Enable,
    output logic [CountWidth-1:0] GrayCount
);

    //========================================
    // Binary count and its Gray image
    //========================================

    // Plain binary count stepped on enabled edges
    logic [CountWidth-1:0] binCount;

    // Next binary value
    logic [CountWidth-1:0] binNext;

    // Gray image of the next value
    logic [CountWidth-1:0] grayNext;

    assign binNext = binCount + CountWidth'(1);

    // Adjacent binary values differ by one Gray bit
    assign grayNext = binNext ^ (binNext >> 1);

    // Both registers step together
    // Gray output comes straight from a flop so it never glitches
    always_ff @(posedge Clk or posedge Clear) begin
        if (Clear) begin
            binCount  <= '0;
            GrayCount <= '0;
        end else if (Enable) begin
            binCount  <= binNext;
            GrayCount <= grayNext;
        end
    end

    //========================================
    // Checks
    //========================================

    // Other clock domain compares this pointer directly
    // Any multi-bit step could show a false equality there
    property pGrayOneBitStep;
        @(posedge Clk) disable iff (Clear)
            (GrayCount != $past(GrayCount)) |-> $onehot(GrayCount ^ $past(GrayCount));
    endproperty

    aGrayOneBitStep: assert property (pGrayOneBitStep)
        else $error("GrayCount stepped by more than one bit: %h -> %h",
                    $past(GrayCount), GrayCount);

endmodule

`default_nettype wire

// ==== hw/fifoDualPortRam.sv ====
//========================================
// FIFO storage array
// Write port on WClk, asynchronous read port
//========================================
`timescale 1ns/1ps
`default_nettype none

module fifoDualPortRam
    import fifoGeometryPkg::*;
#(
    parameter int DataWidth = DefaultDataWidth,
    parameter int AddrWidth = DefaultAddrWidth
) (
    input  wire                  WClk,
    input  wire                  WrEn,
    input  wire  [AddrWidth-1:0] WrAddr,
    input  wire  [DataWidth-1:0] WrData,
    input  wire  [AddrWidth-1:0] RdAddr,
    output logic [DataWidth-1:0] RdData
);

    // One location per pointer value
    localparam int Depth = fifoDepth(AddrWidth);

    //========================================
    // Storage
    //========================================

    // Indexed by Gray pointers directly
    // Gray order only permutes the locations
    logic [DataWidth-1:0] mem [0:Depth-1];

    // Write port
    // Enable already qualified by Full upstream
    always_ff @(posedge WClk) begin
        if (WrEn) begin
            mem[WrAddr] <= WrData;
        end
    end

    //========================================
    // Read port
    //========================================

    // Word at the read pointer, no register
    // Follows the pointer right after each read edge
    assign RdData = mem[RdAddr];

endmodule

`default_nettype wire

// ==== hw/fifoDirectionFsm.sv ====
//========================================
// Quadrant decode and direction state latch
// Full and Empty flag flops with checks
//========================================
`timescale 1ns/1ps
`default_nettype none

module fifoDirectionFsm
    import fifoGeometryPkg::*;
    import fifoStatusPkg::*;
#(
    parameter int AddrWidth = DefaultAddrWidth
) (
    input  wire                 WClk,
    input  wire                 RClk,
    input  wire                 PresetEmpty,
    input  wire [AddrWidth-1:0] WrPtr,
    input  wire [AddrWidth-1:0] RdPtr,
    output logic                Full,
    output logic                Empty
);

    // Quadrant following q in Gray order
    function automatic quadrant_t nextQuadrant(input quadrant_t q);
        case (q)
            Q0:      return Q1;
            Q1:      return Q2;
            Q2:      return Q3;
            default: return Q0;
        endcase
    endfunction

    // Narrow pointers cannot be split into quadrants
    generate
        if (AddrWidth < MinAddrWidth) begin : gBadWidth
            $error("fifoDirectionFsm needs AddrWidth of at least %0d", MinAddrWidth);
        end
    endgenerate

    //========================================
    // Quadrant decode
    //========================================

    quadrant_t wrQuad;
    quadrant_t rdQuad;
    logic      goingFull;
    logic      goingEmpty;

    assign wrQuad = quadrant_t'(WrPtr[AddrWidth-1 -: 2]);
    assign rdQuad = quadrant_t'(RdPtr[AddrWidth-1 -: 2]);

    // Writer one quadrant behind reader
    // e.g. write in Q3 while read sits in Q0
    assign goingFull = (nextQuadrant(wrQuad) == rdQuad);

    // Writer one quadrant ahead of reader
    assign goingEmpty = (nextQuadrant(rdQuad) == wrQuad);

    //========================================
    // Direction state
    //========================================

    dirState_t dirState;

    // Set/reset storage element with no clock
    // Both pointers feed it from different domains
    // The two decodes are mutually exclusive
    always_latch begin
        if (PresetEmpty || goingEmpty) begin
            dirState <= DirGoingEmpty;
        end else if (goingFull) begin
            dirState <= DirGoingFull;
        end
    end

    //========================================
    // Flag flops
    //========================================

    logic ptrEqual;
    logic setFull;
    logic setEmpty;

    assign ptrEqual = (WrPtr == RdPtr);

    // Pointers meet and direction tells which way
    assign setFull  = ptrEqual && (dirState == DirGoingFull);
    assign setEmpty = ptrEqual && (dirState == DirGoingEmpty);

    // Preset at once by the condition
    // Released on the first WClk edge after pointers separate
    always_ff @(posedge WClk or posedge PresetEmpty or posedge setFull) begin
        if (PresetEmpty) begin
            Full <= 1'b0;
        end else if (setFull) begin
            Full <= 1'b1;
        end else begin
            Full <= 1'b0;
        end
    end

    // Same scheme on the read clock
    // Reset simply forces the empty preset
    always_ff @(posedge RClk or posedge PresetEmpty or posedge setEmpty) begin
        if (PresetEmpty || setEmpty) begin
            Empty <= 1'b1;
        end else begin
            Empty <= 1'b0;
        end
    end

    //========================================
    // Checks
    //========================================

    // Direction state makes the two presets exclusive
    aFlagsExclusive: assert property (
        @(posedge WClk) disable iff (PresetEmpty) !(Full && Empty))
        else $error("Full and Empty high together");

    // Reader sees an empty FIFO right after reset
    aEmptyAfterReset: assert property (
        @(posedge RClk) $fell(PresetEmpty) |=> Empty)
        else $error("Empty low after reset release");

endmodule

`default_nettype wire

// ==== hw/asyncFifo.sv ====
//========================================
// Dual-clock FIFO top level
// Enable qualification, RAM, pointers, flags
//========================================
`timescale 1ns/1ps
`default_nettype none

module asyncFifo
    import fifoGeometryPkg::*;
#(
    parameter int DataWidth = DefaultDataWidth,
    parameter int AddrWidth = DefaultAddrWidth
) (
    // Shared reset
    input  wire                  WClk,
    input  wire                  RClk,
    input  wire                  PresetEmpty,

    // Write port on WClk
    input  wire                  WriteEn,
    input  wire  [DataWidth-1:0] DataIn,
    output logic                 Full,

    // Read port on RClk
    input  wire                  ReadEn,
    output logic [DataWidth-1:0] DataOut,
    output logic                 Empty
);

    //========================================
    // Handshake qualification
    //========================================

    // Refused enables change nothing
    logic writeAdvance;
    logic readAdvance;

    assign writeAdvance = WriteEn && !Full;
    assign readAdvance  = ReadEn && !Empty;

    // Gray pointers, one per clock domain
    logic [AddrWidth-1:0] wrPtr;
    logic [AddrWidth-1:0] rdPtr;

    //========================================
    // Storage
    //========================================

    // Word lands at the current write pointer
    // Pointer steps on the same WClk edge
    fifoDualPortRam #(
        .DataWidth (DataWidth),
        .AddrWidth (AddrWidth)
    ) ram_i (
        .WClk   (WClk),
        .WrEn   (writeAdvance),
        .WrAddr (wrPtr),
        .WrData (DataIn),
        .RdAddr (rdPtr),
        .RdData (DataOut)
    );

    //========================================
    // Pointers
    //========================================

    // Write pointer on WClk
    fifoGrayCounter #(
        .CountWidth (AddrWidth)
    ) wrCounter_i (
        .Clk       (WClk),
        .Clear     (PresetEmpty),
        .Enable    (writeAdvance),
        .GrayCount (wrPtr)
    );

    // Read pointer on RClk
    fifoGrayCounter #(
        .CountWidth (AddrWidth)
    ) rdCounter_i (
        .Clk       (RClk),
        .Clear     (PresetEmpty),
        .Enable    (readAdvance),
        .GrayCount (rdPtr)
    );

    //========================================
    // Flags
    //========================================

    // Compares raw Gray pointers across domains
    // No synchronizer chain in this scheme
    fifoDirectionFsm #(
        .AddrWidth (AddrWidth)
    ) directionFsm_i (
        .WClk        (WClk),
        .RClk        (RClk),
        .PresetEmpty (PresetEmpty),
        .WrPtr       (wrPtr),
        .RdPtr       (rdPtr),
        .Full        (Full),
        .Empty       (Empty)
    );

endmodule

`default_nettype wire

// ==== test/asyncFifoTbTable.svh ====
//========================================
// Traffic rows with expected settled flags
//========================================
`ifndef ASYNC_FIFO_TB_TABLE_SVH
`define ASYNC_FIFO_TB_TABLE_SVH

// One row of traffic with writer and reader side by side
// Counts are accepted words
// Extras are pulses that must be refused
typedef struct packed {
    int wrCount;
    int wrExtra;
    int rdCount;
    int rdExtra;
    int wrDuty;
    int rdDuty;
    int expFull;
    int expEmpty;
    int resetAfter;
} tableRow_t;

localparam int RowCount = 9;

// Columns
// wrCount wrExtra rdCount rdExtra wrDuty% rdDuty% Full Empty reset
tableRow_t trafficTable [RowCount] = '{
    // Fill to the top then push against Full
    '{16, 4,  0, 0, 100,   0, 1, 0, 0},
    // Drain everything then pull against Empty
    '{ 0, 0, 16, 4,   0, 100, 0, 1, 0},
    // Balanced bursts at mixed duty
    '{12, 0, 12, 0,  60,  50, 0, 1, 0},
    // Writer ahead with six words left behind
    '{20, 0, 14, 0,  50,  80, 0, 0, 0},
    // Slow reader catches up and empties
    '{10, 0, 16, 0, 100,  40, 0, 1, 0},
    // Partly filled when reset hits
    '{10, 0,  3, 0,  70,  70, 0, 0, 1},
    // Long run past both pointer wraps
    '{40, 0, 40, 0,  90,  60, 0, 1, 0},
    // Refill after the wraps
    '{16, 0,  0, 0, 100,   0, 1, 0, 0},
    // Final drain with a few refused reads
    '{ 0, 0, 16, 3,   0,  70, 0, 1, 0}
};

`endif

// ==== test/asyncFifoTb.sv ====
//========================================
// Testbench for the dual-clock FIFO
// Table-driven traffic with scoreboard
//========================================
`timescale 1ns/1ps
`default_nettype none

module asyncFifoTb;

    //========================================
    // Constants
    //========================================

    localparam int DataWidth     = 8;
    localparam int Depth         = 16;
    localparam int HalfPeriod    = 20;
    localparam int RClkOffset    = 13;
    localparam int ResetCycles   = 4;
    localparam int TimeoutMargin = 200;
    localparam int unsigned Seed = 32'heb8b_01b9;

    `include "asyncFifoTbTable.svh"

    // DUT connections
    logic                 WClk;
    logic                 RClk;
    logic                 PresetEmpty;
    logic                 WriteEn;
    logic [DataWidth-1:0] DataIn;
    logic                 Full;
    logic                 ReadEn;
    logic [DataWidth-1:0] DataOut;
    logic                 Empty;

    // Words accepted by the writer and not yet read
    logic [DataWidth-1:0] scoreboard [$];
    int                   expectedLength;
    int                   cycleCount;
    int                   cycleLimit;

    asyncFifo asyncFifo_i (
        .WClk        (WClk),
        .RClk        (RClk),
        .PresetEmpty (PresetEmpty),
        .WriteEn     (WriteEn),
        .DataIn      (DataIn),
        .Full        (Full),
        .ReadEn      (ReadEn),
        .DataOut     (DataOut),
        .Empty       (Empty)
    );

    //========================================
    // Clocks and timeout
    //========================================

    initial begin
        WClk = 1'b0;
        forever #HalfPeriod WClk = ~WClk;
    end

    // Same period, shifted phase
    initial begin
        RClk = 1'b0;
        #RClkOffset;
        forever #HalfPeriod RClk = ~RClk;
    end

    // Limit scales with the traffic in the table
    initial begin
        cycleLimit = TimeoutMargin;
        foreach (trafficTable[i]) begin
            cycleLimit += 4 * (trafficTable[i].wrCount + trafficTable[i].wrExtra
                               + trafficTable[i].rdCount + trafficTable[i].rdExtra);
        end
        cycleCount = 0;
        forever begin
            @(posedge WClk);
            cycleCount++;
            if (cycleCount >= cycleLimit) begin
                $display("Timeout after %0d WClk cycles, traffic did not finish", cycleCount);
                abortRun();
            end
        end
    end

    //========================================
    // Failure handling
    //========================================

    task automatic abortRun();
        $display("sim failed");
        $fatal(1, "Stopping at first failure");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            abortRun();
        end
    endtask

    //========================================
    // Reset
    //========================================

    // Flags must show an empty FIFO once reset lets go
    task automatic applyReset();
        @(posedge WClk);
        PresetEmpty <= 1'b1;
        repeat (ResetCycles) @(posedge WClk);
        PresetEmpty <= 1'b0;
        scoreboard.delete();
        expectedLength = 0;
        @(negedge WClk);
        checkValue("Full", Full, 0);
        @(negedge RClk);
        checkValue("Empty", Empty, 1);
    endtask

    //========================================
    // Write and read sides
    //========================================

    // Full sampled at the falling edge, stable until the next write edge
    task automatic runWriter(input int count, input int extra, input int duty,
                             input bit checkFull);
        int                   accepted;
        int                   extraDone;
        bit                   active;
        bit                   inExtra;
        bit                   justAccepted;
        bit                   fullSeen;
        bit                   done;
        logic [DataWidth-1:0] word;
        accepted  = 0;
        extraDone = 0;
        active    = 1'b0;
        inExtra   = 1'b0;
        fullSeen  = 1'b0;
        done      = 1'b0;
        word      = '0;
        while (!done) begin
            @(posedge WClk);
            justAccepted = 1'b0;
            // Attempt taken by this edge
            if (active) begin
                if (inExtra) extraDone++;
                if (!fullSeen) begin
                    scoreboard.push_back(word);
                    justAccepted = 1'b1;
                    if (!inExtra) accepted++;
                end
            end
            if (accepted >= count && extraDone >= extra) begin
                active = 1'b0;
                done   = 1'b1;
            end else begin
                active  = ($urandom_range(99) < duty);
                inExtra = (accepted >= count);
                word    = DataWidth'($urandom);
            end
            WriteEn <= active;
            DataIn  <= word;
            @(negedge WClk);
            fullSeen = Full;
            // No reads running, so Full tracks the queue exactly
            if (checkFull && justAccepted) begin
                checkValue("Full", fullSeen, scoreboard.size() == Depth);
            end
        end
    endtask

    // Empty and DataOut sampled half a cycle before the read edge
    task automatic runReader(input int count, input int extra, input int duty,
                             input bit checkEmpty);
        int                   accepted;
        int                   extraDone;
        bit                   active;
        bit                   inExtra;
        bit                   justRead;
        bit                   emptySeen;
        bit                   done;
        logic [DataWidth-1:0] dataSeen;
        logic [DataWidth-1:0] expected;
        accepted  = 0;
        extraDone = 0;
        active    = 1'b0;
        inExtra   = 1'b0;
        emptySeen = 1'b1;
        done      = 1'b0;
        dataSeen  = '0;
        while (!done) begin
            @(posedge RClk);
            justRead = 1'b0;
            if (active) begin
                if (inExtra) extraDone++;
                if (!emptySeen) begin
                    if (scoreboard.size() == 0) begin
                        $display("Read accepted while no written word was pending");
                        abortRun();
                    end
                    expected = scoreboard.pop_front();
                    checkValue("DataOut", dataSeen, expected);
                    justRead = 1'b1;
                    if (!inExtra) accepted++;
                end
            end
            if (accepted >= count && extraDone >= extra) begin
                active = 1'b0;
                done   = 1'b1;
            end else begin
                active  = ($urandom_range(99) < duty);
                inExtra = (accepted >= count);
            end
            ReadEn <= active;
            @(negedge RClk);
            emptySeen = Empty;
            dataSeen  = DataOut;
            if (checkEmpty && justRead) begin
                checkValue("Empty", emptySeen, scoreboard.size() == 0);
            end
        end
    endtask

    //========================================
    // Table loop
    //========================================

    task automatic runRow(input int index);
        tableRow_t row;
        row = trafficTable[index];
        fork
            runWriter(row.wrCount, row.wrExtra, row.wrDuty, (row.rdCount + row.rdExtra) == 0);
            runReader(row.rdCount, row.rdExtra, row.rdDuty, (row.wrCount + row.wrExtra) == 0);
        join
        expectedLength = expectedLength + row.wrCount - row.rdCount;
        // Let Empty catch up with the last write
        repeat (2) @(posedge RClk);
        @(negedge WClk);
        checkValue("Full", Full, row.expFull);
        @(negedge RClk);
        checkValue("Empty", Empty, row.expEmpty);
        checkValue("scoreboard length", scoreboard.size(), expectedLength);
        if (row.resetAfter != 0) applyReset();
    endtask

    initial begin
        void'($urandom(Seed));
        PresetEmpty    = 1'b0;
        WriteEn        = 1'b0;
        DataIn         = '0;
        ReadEn         = 1'b0;
        expectedLength = 0;
        applyReset();
        for (int i = 0; i < RowCount; i++) begin
            runRow(i);
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+test
hw/fifoGeometryPkg.sv
hw/fifoStatusPkg.sv
hw/fifoGrayCounter.sv
hw/fifoDualPortRam.sv
hw/fifoDirectionFsm.sv
hw/asyncFifo.sv
test/asyncFifoTb.sv

// ==== Makefile ====
# Verilator build and run for the dual-clock FIFO testbench

VERILATOR ?= verilator
TOP       := asyncFifoTb
FILELIST  := verilog.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal

SIM       := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) test/asyncFifoTbTable.svh

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Exit status of the simulator is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)
